//--- uart_sys.f
+incdir+design
design/uart_pkg.sv
design/uart_regs.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_top.sv
tests/tb_uart_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the uart testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_uart_top -f uart_sys.f -o sim_uart
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_uart 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

//--- tests/tb_uart_top.sv
/*
 * tb_uart_top: directed tests for the uart subsystem, apb and serial
 * drivers, o_tx monitor, lfsr data, compare tasks and watchdog
 */
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_uart_top;

  localparam int FRAME_DIVS = 3*16 + 3*7 + 6*16 + 4*16 + 3*10;  // frames x divisor, all tests
  localparam int MARGIN_NS  = 40000;                            // apb polls and idle gaps
  localparam int LIMIT_NS   = FRAME_DIVS * 10 * 8 + MARGIN_NS;

  logic                clk;
  logic                rst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  uart_pkg::apb_addr_t paddr;
  uart_pkg::apb_data_t pwdata;
  uart_pkg::apb_data_t prdata;
  logic                drv_line;  // serial driver output
  logic                loop_en;   // o_tx back into i_rx
  logic                rx_line;
  logic                tx_line;
  int                  errors;
  int                  checks;
  logic [31:0]         lfsr;
  uart_pkg::sum_t      exp_sum;   // reference byte sum

  assign rx_line = loop_en ? tx_line : drv_line;

  uart_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .i_rx      (rx_line),
    .o_tx      (tx_line)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    #(LIMIT_NS);
    $display("timeout: tests did not finish within %0d ns", LIMIT_NS);
    $display("Test failed");
    $finish;
  end

  task automatic apb_write(input uart_pkg::apb_addr_t addr, input uart_pkg::apb_data_t data);
    @(posedge clk);
    #1;
    psel    = 1'b1;  // setup
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1 penable = 1'b1;  // access
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input uart_pkg::apb_addr_t addr, output uart_pkg::apb_data_t data);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);
    data = prdata;  // mid access cycle
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_byte(output uart_pkg::byte_t b);
    int k;
    b = '0;
    for (k = 0; k < 8; k++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic check_byte(input string name, input uart_pkg::byte_t got,
                            input uart_pkg::byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_sum(input string name, input uart_pkg::sum_t got,
                           input uart_pkg::sum_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input uart_pkg::apb_data_t got,
                            input uart_pkg::apb_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    checks++;
    errors++;
    $display("%s", msg);
  endtask

  task automatic test_done(input string name, input int err0);
    $display("%s finished with %0d errors", name, errors - err0);
  endtask

  // one bit time on the driver line
  task automatic hold_line(input logic v, input int cycles);
    @(posedge clk);
    #1 drv_line = v;
    repeat (cycles - 1) @(posedge clk);
  endtask

  task automatic send_frame(input uart_pkg::byte_t b, input int div, input logic bad_stop);
    int k;
    hold_line(1'b0, div);  // start
    for (k = 0; k < 8; k++) begin
      hold_line(b[k], div);
    end
    hold_line(!bad_stop, div);
    if (bad_stop) begin
      hold_line(1'b1, 2 * div);  // back to idle
    end
  endtask

  // decodes one o_tx frame at mid-bit, on falling clock edges
  task automatic capture_frame(input int div, output uart_pkg::byte_t b, output logic ok);
    int n;
    int k;
    ok = 1'b0;
    b  = '0;
    n  = 0;
    @(negedge clk);
    while (tx_line && n < 4 * div) begin
      @(negedge clk);
      n++;
    end
    if (tx_line) begin
      report_failure("o_tx never went low for a start bit");
      return;
    end
    repeat (div / 2) @(negedge clk);
    if (tx_line) begin
      report_failure("o_tx start bit was high at mid-bit");
      return;
    end
    for (k = 0; k < 8; k++) begin
      repeat (div) @(negedge clk);
      b[k] = tx_line;  // lsb first
    end
    repeat (div) @(negedge clk);
    if (!tx_line) begin
      report_failure("o_tx stop bit was low");
      return;
    end
    ok = 1'b1;
  endtask

  task automatic watch_idle(input int cycles, input string what);
    logic seen_low;
    seen_low = 1'b0;
    repeat (cycles) begin
      @(negedge clk);
      if (!tx_line) seen_low = 1'b1;
    end
    if (seen_low) report_failure({"o_tx left idle ", what});
  endtask

  task automatic wait_status(input int idx, input logic val, input int polls, input string what);
    uart_pkg::apb_data_t rd;
    int n;
    n = 0;
    apb_read(`UART_REG_STATUS, rd);
    while (rd[idx] !== val && n < polls) begin
      apb_read(`UART_REG_STATUS, rd);
      n++;
    end
    if (rd[idx] !== val) report_failure({what, " did not happen in time"});
  endtask

  task automatic test_reset();
    uart_pkg::apb_data_t rd;
    int err0;
    err0 = errors;
    apb_read(`UART_REG_CTRL, rd);
    check_word("CTRL", rd, 32'h0);
    apb_read(`UART_REG_DIV, rd);
    check_word("DIV", rd, `UART_DIV_RESET);
    apb_read(`UART_REG_STATUS, rd);
    check_word("STATUS", rd, 32'h0);
    apb_read(`UART_REG_SUM, rd);
    check_sum("SUM", rd, '0);
    watch_idle(32, "after reset");
    test_done("reset", err0);
  endtask

  task automatic test_regs();
    uart_pkg::apb_data_t rd;
    int err0;
    err0 = errors;
    apb_write(`UART_REG_DIV, 32'd7);
    apb_read(`UART_REG_DIV, rd);
    check_word("DIV", rd, 32'd7);
    apb_write(`UART_REG_DIV, 32'd1);  // too small, kept at 7
    apb_read(`UART_REG_DIV, rd);
    check_word("DIV", rd, 32'd7);
    apb_write(`UART_REG_CTRL, 32'h3);
    apb_read(`UART_REG_CTRL, rd);
    check_word("CTRL", rd, 32'h3);
    apb_write(`UART_REG_CTRL, 32'h0);
    apb_write(8'h20, 32'hffff_ffff);  // unmapped
    apb_read(8'h20, rd);
    check_word("unmapped 0x20", rd, 32'h0);
    apb_read(`UART_REG_CTRL, rd);
    check_word("CTRL", rd, 32'h0);
    apb_write(`UART_REG_DIV, 32'd16);
    test_done("registers", err0);
  endtask

  task automatic test_tx();
    int divs[2];
    int d;
    int i;
    uart_pkg::byte_t b;
    uart_pkg::byte_t got;
    uart_pkg::apb_data_t rd;
    logic ok;
    int err0;
    err0    = errors;
    divs[0] = 16;
    divs[1] = 7;
    apb_write(`UART_REG_CTRL, 32'h2);  // tx only
    for (d = 0; d < 2; d++) begin
      apb_write(`UART_REG_DIV, uart_pkg::apb_data_t'(divs[d]));
      for (i = 0; i < 3; i++) begin
        next_byte(b);
        apb_write(`UART_REG_TXDATA, uart_pkg::apb_data_t'(b));
        fork
          capture_frame(divs[d], got, ok);
          begin
            apb_read(`UART_REG_STATUS, rd);
            check_word("STATUS.tx_busy", rd & 32'h1, 32'h1);
            apb_write(`UART_REG_TXDATA, uart_pkg::apb_data_t'(~b));  // dropped while busy
          end
        join
        if (ok) check_byte("o_tx frame", got, b);
        wait_status(0, 1'b0, 4 * divs[d], "tx_busy clear");
        watch_idle(2 * divs[d], "after a write made while busy");
        apb_read(`UART_REG_TXDATA, rd);
        check_word("TXDATA", rd, uart_pkg::apb_data_t'(b));
      end
    end
    test_done("transmit", err0);
  endtask

  task automatic test_rx();
    int i;
    uart_pkg::byte_t b;
    uart_pkg::apb_data_t rd;
    int err0;
    err0 = errors;
    apb_write(`UART_REG_DIV, 32'd16);
    apb_write(`UART_REG_CTRL, 32'h1);  // rx only
    apb_write(`UART_REG_SUM, 32'h0);
    exp_sum = '0;
    for (i = 0; i < 6; i++) begin
      next_byte(b);
      send_frame(b, 16, 1'b0);
      wait_status(1, 1'b1, 16, "rx_full set");
      apb_read(`UART_REG_RXDATA, rd);
      check_byte("RXDATA", rd[7:0], b);
      exp_sum = exp_sum + uart_pkg::sum_t'(b);
      apb_read(`UART_REG_STATUS, rd);
      check_word("STATUS", rd, 32'h0);  // read cleared rx_full
    end
    apb_read(`UART_REG_SUM, rd);
    check_sum("SUM", rd, exp_sum);
    apb_write(`UART_REG_SUM, 32'h1);
    exp_sum = '0;
    apb_read(`UART_REG_SUM, rd);
    check_sum("SUM", rd, exp_sum);
    test_done("receive", err0);
  endtask

  task automatic test_errors();
    uart_pkg::byte_t b;
    uart_pkg::byte_t b2;
    uart_pkg::apb_data_t rd;
    int err0;
    err0 = errors;
    next_byte(b);
    send_frame(b, 16, 1'b1);  // low stop bit, byte dropped
    apb_read(`UART_REG_STATUS, rd);
    check_word("STATUS", rd, 32'h0);
    apb_read(`UART_REG_SUM, rd);
    check_sum("SUM", rd, exp_sum);
    next_byte(b);
    next_byte(b2);
    send_frame(b, 16, 1'b0);
    send_frame(b2, 16, 1'b0);  // no read in between
    exp_sum = exp_sum + uart_pkg::sum_t'(b) + uart_pkg::sum_t'(b2);
    wait_status(1, 1'b1, 16, "rx_full set");
    apb_read(`UART_REG_STATUS, rd);
    check_word("STATUS", rd, 32'h6);
    apb_read(`UART_REG_RXDATA, rd);
    check_byte("RXDATA", rd[7:0], b2);
    apb_write(`UART_REG_STATUS, 32'h4);
    apb_read(`UART_REG_STATUS, rd);
    check_word("STATUS", rd, 32'h0);
    apb_write(`UART_REG_CTRL, 32'h0);  // rx off
    next_byte(b);
    send_frame(b, 16, 1'b0);
    apb_read(`UART_REG_STATUS, rd);
    check_word("STATUS", rd, 32'h0);
    apb_read(`UART_REG_SUM, rd);
    check_sum("SUM", rd, exp_sum);
    test_done("errors", err0);
  endtask

  task automatic test_loopback();
    int i;
    uart_pkg::byte_t b;
    uart_pkg::apb_data_t rd;
    int err0;
    err0    = errors;
    loop_en = 1'b1;
    apb_write(`UART_REG_DIV, 32'd10);
    apb_write(`UART_REG_CTRL, 32'h3);
    for (i = 0; i < 3; i++) begin
      next_byte(b);
      apb_write(`UART_REG_TXDATA, uart_pkg::apb_data_t'(b));
      wait_status(1, 1'b1, 60, "loopback rx_full set");
      apb_read(`UART_REG_RXDATA, rd);
      check_byte("RXDATA loopback", rd[7:0], b);
      exp_sum = exp_sum + uart_pkg::sum_t'(b);
      wait_status(0, 1'b0, 20, "tx_busy clear");  // next write would be dropped
    end
    apb_read(`UART_REG_SUM, rd);
    check_sum("SUM", rd, exp_sum);
    loop_en = 1'b0;
    test_done("loopback", err0);
  endtask

  initial begin
    rst_n    = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    drv_line = 1'b1;  // serial idle
    loop_en  = 1'b0;
    errors   = 0;
    checks   = 0;
    lfsr     = 32'h52f2765f;
    exp_sum  = '0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    test_reset();
    test_regs();
    test_tx();
    test_rx();
    test_errors();
    test_loopback();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- design/uart_top.sv
/*
 * uart_top: apb register block, 8N1 receiver and transmitter
 */
`timescale 1ns/1ps

module uart_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  uart_pkg::apb_addr_t i_paddr,
  input  uart_pkg::apb_data_t i_pwdata,
  output uart_pkg::apb_data_t o_prdata,
  input  logic                i_rx,
  output logic                o_tx
);

  uart_pkg::uart_cfg_t cfg;      // shared by rx and tx
  uart_pkg::tx_req_t   tx_req;
  uart_pkg::rx_byte_t  rx_byte;
  uart_pkg::sum_t      rx_sum;
  logic                tx_busy;
  logic                sum_clr;

  uart_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_cfg     (cfg),
    .o_tx_req  (tx_req),
    .i_tx_busy (tx_busy),
    .i_rx_byte (rx_byte),
    .i_sum     (rx_sum),
    .o_sum_clr (sum_clr)
  );

  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_cfg     (cfg),
    .i_rx      (i_rx),
    .i_sum_clr (sum_clr),
    .o_rx_byte (rx_byte),
    .o_sum     (rx_sum)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_cfg    (cfg),
    .i_tx_req (tx_req),
    .o_tx     (o_tx),
    .o_busy   (tx_busy)
  );

endmodule

//--- design/uart_tx.sv
/*
 * uart_tx: 8N1 transmitter, start bit, 8 data bits lsb first, stop bit
 */
`timescale 1ns/1ps

module uart_tx (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_pkg::uart_cfg_t i_cfg,
  input  uart_pkg::tx_req_t   i_tx_req,
  output logic                o_tx,
  output logic                o_busy
);

  uart_pkg::tx_state_t state;
  uart_pkg::divisor_t  div_q;    // divisor frozen for the frame
  uart_pkg::divisor_t  cnt;
  logic [2:0]          bit_idx;
  uart_pkg::byte_t     shift_q;  // next bit at [0]
  logic                tx_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx_q    <= 1'b1;  // idle line high
    end else begin
      case (state)
        uart_pkg::TX_IDLE: begin
          if (i_tx_req.start && i_cfg.tx_en) begin
            state <= uart_pkg::TX_START;
            cnt   <= i_cfg.divisor - uart_pkg::divisor_t'(1);
            tx_q  <= 1'b0;  // start bit
          end
        end
        uart_pkg::TX_START: begin
          if (cnt != '0) begin
            cnt <= cnt - uart_pkg::divisor_t'(1);
          end else begin
            state   <= uart_pkg::TX_DATA;
            cnt     <= div_q - uart_pkg::divisor_t'(1);
            bit_idx <= '0;
            tx_q    <= shift_q[0];
          end
        end
        uart_pkg::TX_DATA: begin
          if (cnt != '0) begin
            cnt <= cnt - uart_pkg::divisor_t'(1);
          end else begin
            cnt <= div_q - uart_pkg::divisor_t'(1);
            if (bit_idx == 3'd7) begin
              state <= uart_pkg::TX_STOP;
              tx_q  <= 1'b1;  // stop bit
            end else begin
              bit_idx <= bit_idx + 3'd1;
              tx_q    <= shift_q[1];
            end
          end
        end
        uart_pkg::TX_STOP: begin
          if (cnt != '0) cnt <= cnt - uart_pkg::divisor_t'(1);
          else state <= uart_pkg::TX_IDLE;  // busy drops here
        end
        default: state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  // payload path, loaded at launch and shifted per data bit
  always_ff @(posedge clk) begin
    if (state == uart_pkg::TX_IDLE && i_tx_req.start && i_cfg.tx_en) begin
      shift_q <= i_tx_req.data;
      div_q   <= i_cfg.divisor;
    end else if (state == uart_pkg::TX_DATA && cnt == '0) begin
      shift_q <= shift_q >> 1;
    end
  end

  assign o_tx   = tx_q;
  assign o_busy = (state != uart_pkg::TX_IDLE);

  // the stop bit leaves the line high on the way back to idle
  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    (state == uart_pkg::TX_IDLE) |-> o_tx);

endmodule

//--- design/uart_rx.sv
/*
 * uart_rx 8N1 receiver with input synchronizer, mid-bit sampling,
 * lsb-first byte assembly and a running 32-bit byte sum
 */
`timescale 1ns/1ps

module uart_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_pkg::uart_cfg_t i_cfg,
  input  logic                i_rx,
  input  logic                i_sum_clr,
  output uart_pkg::rx_byte_t  o_rx_byte,
  output uart_pkg::sum_t      o_sum
);

  logic                rx_meta;   // first sync stage
  logic                rx_sync;   // second sync stage
  logic                rx_prev;   // for falling edge detect
  uart_pkg::rx_state_t state;
  uart_pkg::divisor_t  cnt;       // cycles left in current wait
  logic [2:0]          bit_idx;   // data bit cursor
  uart_pkg::byte_t     shift_q;   // fills from the msb downward
  logic                valid_q;
  uart_pkg::sum_t      sum_q;
  logic                stop_ok;   // stop bit sampled high

  assign stop_ok = i_cfg.rx_en && (state == uart_pkg::RX_STOP) && (cnt == '0) && rx_sync;

  // sync chain resets to the idle line level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::RX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
    end else if (!i_cfg.rx_en) begin
      state <= uart_pkg::RX_IDLE;  // park in idle while disabled
    end else begin
      case (state)
        uart_pkg::RX_IDLE: begin
          if (rx_prev && !rx_sync) begin
            state <= uart_pkg::RX_START;
            cnt   <= (i_cfg.divisor >> 1) - uart_pkg::divisor_t'(1);  // half bit
          end
        end
        uart_pkg::RX_START: begin
          if (cnt != '0) begin
            cnt <= cnt - uart_pkg::divisor_t'(1);
          end else if (rx_sync) begin
            state <= uart_pkg::RX_IDLE;  // line back high means a glitch
          end else begin
            state   <= uart_pkg::RX_DATA;
            cnt     <= i_cfg.divisor - uart_pkg::divisor_t'(1);
            bit_idx <= '0;
          end
        end
        uart_pkg::RX_DATA: begin
          if (cnt != '0) begin
            cnt <= cnt - uart_pkg::divisor_t'(1);
          end else begin
            cnt     <= i_cfg.divisor - uart_pkg::divisor_t'(1);
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) state <= uart_pkg::RX_STOP;
          end
        end
        uart_pkg::RX_STOP: begin
          if (cnt != '0) cnt <= cnt - uart_pkg::divisor_t'(1);
          else state <= uart_pkg::RX_IDLE;  // bad stop just drops the byte
        end
        default: state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // payload shift register
  always_ff @(posedge clk) begin
    if (state == uart_pkg::RX_DATA && cnt == '0) shift_q <= {rx_sync, shift_q[7:1]};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      sum_q   <= '0;
    end else begin
      valid_q <= stop_ok;
      if (i_sum_clr) sum_q <= '0;  // clear wins over a same-cycle byte
      else if (stop_ok) sum_q <= sum_q + uart_pkg::sum_t'(shift_q);
    end
  end

  assign o_rx_byte = '{valid: valid_q, data: shift_q};
  assign o_sum     = sum_q;

  // one valid pulse per received frame
  a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    o_rx_byte.valid |=> !o_rx_byte.valid);

endmodule

//--- design/uart_regs.sv
/*
 * uart_regs apb register block with ctrl, divisor, tx launch,
 * rx holding register, status flags and byte sum readback
 */
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  uart_pkg::apb_addr_t i_paddr,
  input  uart_pkg::apb_data_t i_pwdata,
  output uart_pkg::apb_data_t o_prdata,
  output uart_pkg::uart_cfg_t o_cfg,
  output uart_pkg::tx_req_t   o_tx_req,
  input  logic                i_tx_busy,
  input  uart_pkg::rx_byte_t  i_rx_byte,
  input  uart_pkg::sum_t      i_sum,
  output logic                o_sum_clr
);

  logic               wr_en;     // write access cycle
  logic               rd_en;     // read access cycle
  logic               rx_en_q;
  logic               tx_en_q;
  uart_pkg::divisor_t div_q;
  uart_pkg::divisor_t div_wr;    // divisor field of write data
  logic               div_ok;    // reject 0 and 1
  logic               launch;
  logic               start_q;
  uart_pkg::byte_t    txdata_q;
  uart_pkg::byte_t    rxdata_q;
  logic               rx_full_q;
  logic               overrun_q;

  assign wr_en  = i_psel && i_penable && i_pwrite;
  assign rd_en  = i_psel && i_penable && !i_pwrite;
  assign div_wr = i_pwdata[`UART_DIV_W-1:0];
  assign div_ok = (div_wr > uart_pkg::divisor_t'(1));

  // writes while busy or disabled are dropped
  assign launch = wr_en && (i_paddr == `UART_REG_TXDATA) && tx_en_q && !i_tx_busy;

  // config registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_en_q <= 1'b0;
      tx_en_q <= 1'b0;
      div_q   <= uart_pkg::divisor_t'(`UART_DIV_RESET);
    end else if (wr_en) begin
      if (i_paddr == `UART_REG_CTRL) begin
        rx_en_q <= i_pwdata[0];
        tx_en_q <= i_pwdata[1];
      end
      if (i_paddr == `UART_REG_DIV && div_ok) div_q <= div_wr;
    end
  end

  // launch pulse one edge after the access cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) start_q <= 1'b0;
    else start_q <= launch;
  end

  always_ff @(posedge clk) begin
    if (launch) txdata_q <= i_pwdata[7:0];
  end

  // rx holding register takes every new byte
  always_ff @(posedge clk) begin
    if (i_rx_byte.valid) rxdata_q <= i_rx_byte.data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_full_q <= 1'b0;
      overrun_q <= 1'b0;
    end else begin
      if (i_rx_byte.valid) rx_full_q <= 1'b1;  // set beats the read clear
      else if (rd_en && i_paddr == `UART_REG_RXDATA) rx_full_q <= 1'b0;
      if (i_rx_byte.valid && rx_full_q) overrun_q <= 1'b1;
      else if (wr_en && i_paddr == `UART_REG_STATUS && i_pwdata[2]) overrun_q <= 1'b0;
    end
  end

  // sum clear lands on the edge ending the access cycle
  assign o_sum_clr = wr_en && (i_paddr == `UART_REG_SUM);

  always_comb begin
    o_prdata = '0;  // unmapped reads 0
    case (i_paddr)
      `UART_REG_CTRL:   o_prdata = uart_pkg::apb_data_t'({tx_en_q, rx_en_q});
      `UART_REG_DIV:    o_prdata = uart_pkg::apb_data_t'(div_q);
      `UART_REG_TXDATA: o_prdata = uart_pkg::apb_data_t'(txdata_q);
      `UART_REG_RXDATA: o_prdata = uart_pkg::apb_data_t'(rxdata_q);
      `UART_REG_STATUS: o_prdata = uart_pkg::apb_data_t'({overrun_q, rx_full_q, i_tx_busy});
      `UART_REG_SUM:    o_prdata = uart_pkg::apb_data_t'(i_sum);
      default:          o_prdata = '0;
    endcase
  end

  assign o_cfg    = '{rx_en: rx_en_q, tx_en: tx_en_q, divisor: div_q};
  assign o_tx_req = '{start: start_q, data: txdata_q};

  // tx must still be idle when the launch pulse rises
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_tx_req.start) |-> !i_tx_busy);

  // a divisor below 2 would leave no mid-bit point
  a_div_reject: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_en && i_paddr == `UART_REG_DIV && div_wr < uart_pkg::divisor_t'(2)) |=> $stable(div_q));

endmodule

//--- design/uart_pkg.sv
/*
 * uart_pkg: shared vector types, fsm state enums and the structs
 * passed between register block, receiver and transmitter
 */
`include "uart_params.svh"

package uart_pkg;

  typedef logic [7:0]              byte_t;     // one data byte
  typedef logic [`UART_DIV_W-1:0]  divisor_t;  // clock cycles per bit
  typedef logic [`UART_SUM_W-1:0]  sum_t;      // wraps mod 2^32
  typedef logic [`UART_ADDR_W-1:0] apb_addr_t;
  typedef logic [`UART_DATA_W-1:0] apb_data_t;

  typedef enum logic [1:0] {
    RX_IDLE,   // waiting for falling edge
    RX_START,  // half-bit wait, start recheck
    RX_DATA,   // 8 data bits, lsb first
    RX_STOP    // stop bit sample
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  // configuration steered from the register block
  typedef struct packed {
    logic     rx_en;
    logic     tx_en;
    divisor_t divisor;
  } uart_cfg_t;

  typedef struct packed {
    logic  valid;  // one-cycle pulse per good frame
    byte_t data;
  } rx_byte_t;

  typedef struct packed {
    logic  start;  // one-cycle launch pulse
    byte_t data;
  } tx_req_t;

endpackage

//--- design/uart_params.svh
/*
 * widths, register offsets and reset value for the uart subsystem
 */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

`define UART_DIV_W      16     // bit-period divisor width
`define UART_SUM_W      32     // running byte sum width
`define UART_ADDR_W     8      // apb address width
`define UART_DATA_W     32     // apb data width
`define UART_DIV_RESET  16     // cycles per bit after reset

`define UART_REG_CTRL    8'h00  // [0] rx_en, [1] tx_en
`define UART_REG_DIV     8'h04  // cycles per bit, 0 and 1 rejected
`define UART_REG_TXDATA  8'h08  // write launches a byte
`define UART_REG_RXDATA  8'h0C  // read clears rx_full
`define UART_REG_STATUS  8'h10  // [0] tx_busy, [1] rx_full, [2] overrun (w1c)
`define UART_REG_SUM     8'h14  // any write clears

`endif
